/* source/limb_link_pkg.sv */
package limb_link_pkg;

    //////////////////////////////
    // spi timing
    //////////////////////////////

    // clocks per sck half period
    localparam int sck_half_period = 13;
    // bits per link frame
    localparam int frame_bits = 32;

    //////////////////////////////
    // widths and types
    //////////////////////////////

    // one data word: coefficients, length, rate, bus data
    typedef logic [31:0] word_t;
    // word index into the register map
    typedef logic [3:0] reg_addr_t;
    // received frame count, wraps
    typedef logic [7:0] frame_count_t;
    // bit position inside a frame
    typedef logic [4:0] bit_index_t;
    // sck half period divider
    typedef logic [$clog2(sck_half_period)-1:0] half_count_t;
    // received bit count, one past a full frame flags a long frame
    typedef logic [$clog2(frame_bits):0] bit_count_t;

    // host to slave half of wishbone
    typedef struct packed {
        logic      cyc;
        logic      stb;
        logic      we;
        reg_addr_t adr;
        word_t     dat;
    } wb_req_t;

    // slave to host half
    typedef struct packed {
        logic  ack;
        word_t dat;
    } wb_rsp_t;

    // one serial lane, one direction
    typedef struct packed {
        logic sck;
        logic ssel_n;
        logic data;
    } spi_link_t;

    // coefficient bank, field order is the address order
    typedef struct packed {
        word_t pps_coef_ia;
        word_t pps_coef_ii;
        word_t spike_gain;
        word_t gamma_dyn;
        word_t gamma_sta;
        word_t mn_gain;
        word_t bdamp_bag1;
        word_t bdamp_bag2;
        word_t bdamp_chain;
    } model_params_t;

    // length sender fsm
    typedef enum logic [1:0] {
        idle,
        shift,
        finish
    } sender_state_t;

    //////////////////////////////
    // register map
    //////////////////////////////

    localparam reg_addr_t addr_coef_first = 4'd0;
    localparam reg_addr_t addr_coef_last  = 4'd8;
    // write starts a frame
    localparam reg_addr_t addr_length     = 4'd9;
    // read only, read clears rx_valid
    localparam reg_addr_t addr_rate       = 4'd10;
    // read only, any write clears overrun
    localparam reg_addr_t addr_status     = 4'd11;

    // ieee single encodings of the model defaults
    localparam model_params_t params_default = '{
        pps_coef_ia: 32'h3F66_6666,  // 0.9
        pps_coef_ii: 32'h3F66_6666,  // 0.9
        spike_gain:  32'h0000_0000,
        gamma_dyn:   32'h42A0_0000,  // 80.0
        gamma_sta:   32'h42A0_0000,  // 80.0
        mn_gain:     32'h0000_0001,  // plain integer
        bdamp_bag1:  32'h3E71_4120,  // 0.2356
        bdamp_bag2:  32'h3D14_4674,  // 0.0362
        bdamp_chain: 32'h3C58_44D0   // 0.0132
    };

    // quiet lane, sck low and deselected
    localparam spi_link_t link_idle = '{sck: 1'b0, ssel_n: 1'b1, data: 1'b0};

endpackage

/* source/host_regs.sv */
`timescale 1ns/1ps

module host_regs (
    input  logic                         ep50trig,
    input  logic                         reset_global,
    input  limb_link_pkg::wb_req_t       wb_req,
    output limb_link_pkg::wb_rsp_t       wb_rsp,
    input  logic                         busy,
    input  limb_link_pkg::word_t         rx_word,
    input  logic                         rx_strobe,
    output logic                         send_req,
    output limb_link_pkg::word_t         length_word,
    output limb_link_pkg::model_params_t model_params
);

    // coefficient bank, entry 0 sits in the msbs like the first struct field
    limb_link_pkg::word_t [limb_link_pkg::addr_coef_first:limb_link_pkg::addr_coef_last] coef_q;

    limb_link_pkg::word_t         length_q;
    limb_link_pkg::word_t         rate_q;
    limb_link_pkg::word_t         rd_data;
    limb_link_pkg::word_t         rd_data_q;
    limb_link_pkg::word_t         status_word;
    limb_link_pkg::frame_count_t  frame_count_q;
    logic                         served_q;
    logic                         ack_q;
    logic                         take;
    logic                         wr_take;
    logic                         rd_take;
    logic                         is_coef;
    logic                         length_wr;
    logic                         send_req_q;
    logic                         rx_valid_q;
    logic                         overrun_q;

    //////////////////////////////
    // bus handshake
    //////////////////////////////

    // new access only once stb has been low since the last one
    assign take    = wb_req.cyc & wb_req.stb & ~served_q;
    assign wr_take = take & wb_req.we;
    assign rd_take = take & ~wb_req.we;

    assign is_coef   = wb_req.adr <= limb_link_pkg::addr_coef_last;
    assign length_wr = wr_take && (wb_req.adr == limb_link_pkg::addr_length);

    // busy in bit 0, rx_valid bit 1, overrun bit 2, count in 15:8
    assign status_word = {16'd0, frame_count_q, 5'd0, overrun_q, rx_valid_q, busy};

    // read mux
    always_comb begin
        rd_data = '0;
        case (wb_req.adr)
            limb_link_pkg::addr_length: rd_data = length_q;
            limb_link_pkg::addr_rate:   rd_data = rate_q;
            limb_link_pkg::addr_status: rd_data = status_word;
            default: begin
                if (is_coef) begin
                    rd_data = coef_q[wb_req.adr];
                end
            end
        endcase
    end

    // read data held for the ack cycle
    always_ff @(posedge ep50trig) begin
        if (take) begin
            rd_data_q <= rd_data;
        end
    end

    //////////////////////////////
    // register storage
    //////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            coef_q   <= limb_link_pkg::params_default;
            length_q <= '0;
        end else if (wr_take) begin
            if (is_coef) begin
                coef_q[wb_req.adr] <= wb_req.dat;
            end
            // length write during a frame is dropped
            if (length_wr && !busy) begin
                length_q <= wb_req.dat;
            end
        end
    end

    // handshake, frame start and link status
    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            served_q      <= 1'b0;
            ack_q         <= 1'b0;
            send_req_q    <= 1'b0;
            overrun_q     <= 1'b0;
            rx_valid_q    <= 1'b0;
            frame_count_q <= '0;
            rate_q        <= '0;
        end else begin
            served_q   <= wb_req.cyc & wb_req.stb;
            ack_q      <= take;
            send_req_q <= length_wr && !busy;
            if (length_wr && busy) begin
                overrun_q <= 1'b1;
            end else if (wr_take && (wb_req.adr == limb_link_pkg::addr_status)) begin
                overrun_q <= 1'b0;
            end
            // a fresh frame wins over a clearing read
            if (rx_strobe) begin
                rx_valid_q    <= 1'b1;
                rate_q        <= rx_word;
                frame_count_q <= frame_count_q + 1'b1;
            end else if (rd_take && (wb_req.adr == limb_link_pkg::addr_rate)) begin
                rx_valid_q <= 1'b0;
            end
        end
    end

    assign wb_rsp.ack   = ack_q;
    assign wb_rsp.dat   = rd_data_q;
    assign send_req     = send_req_q;
    assign length_word  = length_q;
    assign model_params = limb_link_pkg::model_params_t'(coef_q);

    // one ack per access
    ack_single: assert property (@(posedge ep50trig) disable iff (reset_global)
        ack_q |=> !ack_q);

    // sender must be idle when a frame is requested
    send_when_idle: assert property (@(posedge ep50trig) disable iff (reset_global)
        send_req_q |-> !busy);

endmodule

/* source/spi_length_sender.sv */
`timescale 1ns/1ps

module spi_length_sender (
    input  logic                     ep50trig,
    input  logic                     reset_global,
    input  logic                     send_req,
    input  limb_link_pkg::word_t     length_word,
    output logic                     busy,
    output limb_link_pkg::spi_link_t link_tx
);

    limb_link_pkg::sender_state_t state_q;
    limb_link_pkg::half_count_t   div_q;
    limb_link_pkg::bit_index_t    bit_q;
    limb_link_pkg::word_t         shift_q;
    logic                         sck_q;
    logic                         ssel_n_q;
    logic                         half_done;

    // last clock of a half period
    assign half_done = div_q == limb_link_pkg::half_count_t'(limb_link_pkg::sck_half_period - 1);

    //////////////////////////////
    // frame fsm
    //////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            state_q  <= limb_link_pkg::idle;
            div_q    <= '0;
            bit_q    <= '0;
            shift_q  <= '0;
            sck_q    <= 1'b0;
            ssel_n_q <= 1'b1;
        end else begin
            case (state_q)
                limb_link_pkg::idle: begin
                    if (send_req) begin
                        // latch word, msb goes out with select
                        state_q  <= limb_link_pkg::shift;
                        shift_q  <= length_word;
                        div_q    <= '0;
                        bit_q    <= limb_link_pkg::bit_index_t'(limb_link_pkg::frame_bits - 1);
                        sck_q    <= 1'b0;
                        ssel_n_q <= 1'b0;
                    end
                end
                limb_link_pkg::shift: begin
                    if (!half_done) begin
                        div_q <= div_q + 1'b1;
                    end else begin
                        div_q <= '0;
                        if (!sck_q) begin
                            // rising edge, receiver samples here
                            sck_q <= 1'b1;
                        end else begin
                            // falling edge moves the data
                            sck_q   <= 1'b0;
                            shift_q <= {shift_q[30:0], 1'b0};
                            if (bit_q == '0) begin
                                state_q  <= limb_link_pkg::finish;
                                ssel_n_q <= 1'b1;
                            end else begin
                                bit_q <= bit_q - 1'b1;
                            end
                        end
                    end
                end
                limb_link_pkg::finish: begin
                    // one deselected half period before the next frame
                    if (half_done) begin
                        div_q   <= '0;
                        state_q <= limb_link_pkg::idle;
                    end else begin
                        div_q <= div_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= limb_link_pkg::idle;
                end
            endcase
        end
    end

    assign busy           = state_q != limb_link_pkg::idle;
    assign link_tx.sck    = sck_q;
    assign link_tx.ssel_n = ssel_n_q;
    assign link_tx.data   = shift_q[31];

    // select held across the whole frame
    ssel_framed: assert property (@(posedge ep50trig) disable iff (reset_global)
        (busy && state_q != limb_link_pkg::finish) |-> !link_tx.ssel_n);

endmodule

/* source/spi_rate_receiver.sv */
`timescale 1ns/1ps

module spi_rate_receiver (
    input  logic                     ep50trig,
    input  logic                     reset_global,
    input  limb_link_pkg::spi_link_t link_rx,
    output limb_link_pkg::word_t     rx_word,
    output logic                     rx_strobe
);

    limb_link_pkg::spi_link_t  sync1_q;
    limb_link_pkg::spi_link_t  sync2_q;
    limb_link_pkg::bit_count_t count_q;
    limb_link_pkg::word_t      shift_q;
    limb_link_pkg::word_t      rx_word_q;
    logic                      sck_prev_q;
    logic                      ssel_prev_q;
    logic                      sck_rise;
    logic                      ssel_rise;
    logic                      frame_full;
    logic [1:0]                publish_q;
    logic                      rx_strobe_q;

    //////////////////////////////
    // synchronizer, edge detect
    //////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            sync1_q     <= limb_link_pkg::link_idle;
            sync2_q     <= limb_link_pkg::link_idle;
            sck_prev_q  <= 1'b0;
            ssel_prev_q <= 1'b1;
        end else begin
            sync1_q     <= link_rx;
            sync2_q     <= sync1_q;
            sck_prev_q  <= sync2_q.sck;
            ssel_prev_q <= sync2_q.ssel_n;
        end
    end

    assign sck_rise   = sync2_q.sck & ~sck_prev_q;
    assign ssel_rise  = sync2_q.ssel_n & ~ssel_prev_q;
    // exactly one frame worth of bits
    assign frame_full = count_q == limb_link_pkg::bit_count_t'(limb_link_pkg::frame_bits);

    //////////////////////////////
    // bit count and publish
    //////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_global) begin
        if (reset_global) begin
            count_q     <= '0;
            publish_q   <= '0;
            rx_strobe_q <= 1'b0;
        end else begin
            if (sync2_q.ssel_n) begin
                count_q <= '0;
            end else if (sck_rise && count_q <= limb_link_pkg::bit_count_t'(limb_link_pkg::frame_bits)) begin
                // saturates one past full so long frames are dropped
                count_q <= count_q + 1'b1;
            end
            // fixed three cycle latency from deselect
            publish_q   <= {publish_q[0], ssel_rise & frame_full};
            rx_strobe_q <= publish_q[1];
        end
    end

    // shift register, msb first
    always_ff @(posedge ep50trig) begin
        if (sck_rise && !sync2_q.ssel_n) begin
            shift_q <= {shift_q[30:0], sync2_q.data};
        end
        if (publish_q[0]) begin
            rx_word_q <= shift_q;
        end
    end

    assign rx_word   = rx_word_q;
    assign rx_strobe = rx_strobe_q;

    // one strobe per frame
    strobe_single: assert property (@(posedge ep50trig) disable iff (reset_global)
        rx_strobe |=> !rx_strobe);

endmodule

/* source/limb_link_top.sv */
`timescale 1ns/1ps

module limb_link_top (
    input  logic                         ep50trig,
    input  logic                         reset_global,
    input  limb_link_pkg::wb_req_t       wb_req,
    output limb_link_pkg::wb_rsp_t       wb_rsp,
    output limb_link_pkg::spi_link_t     link_tx,
    input  limb_link_pkg::spi_link_t     link_rx,
    output limb_link_pkg::model_params_t model_params
);

    // register block to sender
    logic                 send_req;
    limb_link_pkg::word_t length_word;
    logic                 busy;
    // receiver to register block
    limb_link_pkg::word_t rx_word;
    logic                 rx_strobe;

    host_regs host_regs0 (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .wb_req       (wb_req),
        .wb_rsp       (wb_rsp),
        .busy         (busy),
        .rx_word      (rx_word),
        .rx_strobe    (rx_strobe),
        .send_req     (send_req),
        .length_word  (length_word),
        .model_params (model_params)
    );

    // outgoing muscle length lane
    spi_length_sender sender0 (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .send_req     (send_req),
        .length_word  (length_word),
        .busy         (busy),
        .link_tx      (link_tx)
    );

    // incoming ia rate lane
    spi_rate_receiver receiver0 (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .link_rx      (link_rx),
        .rx_word      (rx_word),
        .rx_strobe    (rx_strobe)
    );

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic ep50trig,
    output logic reset_global
);

    // 40 ns period
    initial begin
        ep50trig = 1'b0;
        forever begin
            #20 ep50trig = ~ep50trig;
        end
    end

    // reset held over three rising edges, released on an edge
    initial begin
        reset_global = 1'b1;
        repeat (3) @(posedge ep50trig);
        reset_global <= 1'b0;
    end

endmodule

/* testbench/tb_limb_link.sv */
`timescale 1ns/1ps

module tb_limb_link;

    logic                         ep50trig;
    logic                         reset_global;
    limb_link_pkg::wb_req_t       wb_req;
    limb_link_pkg::wb_rsp_t       wb_rsp;
    limb_link_pkg::spi_link_t     link_tx;
    limb_link_pkg::model_params_t model_params;

    // expected values the assertions compare against
    logic                         chk_en;
    limb_link_pkg::word_t         chk_exp;
    limb_link_pkg::word_t         exp_coef [0:8];
    limb_link_pkg::model_params_t exp_params;
    limb_link_pkg::frame_count_t  exp_count;
    limb_link_pkg::word_t         rng_state;
    int                           errors;
    int                           timeouts;
    int                           reads;

    tb_clock_gen clock_gen0 (
        .ep50trig     (ep50trig),
        .reset_global (reset_global)
    );

    // sender output looped straight back into the receiver
    limb_link_top dut0 (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .wb_req       (wb_req),
        .wb_rsp       (wb_rsp),
        .link_tx      (link_tx),
        .link_rx      (link_tx),
        .model_params (model_params)
    );

    // shadow bank, address 0 in the top field
    assign exp_params = {exp_coef[0], exp_coef[1], exp_coef[2], exp_coef[3], exp_coef[4],
                         exp_coef[5], exp_coef[6], exp_coef[7], exp_coef[8]};

    //////////////////////////////
    // checkers
    //////////////////////////////

    // fresh stb gets its ack on the next cycle
    ack_follows_stb: assert property (@(posedge ep50trig) disable iff (reset_global)
        (wb_req.cyc && wb_req.stb && !$past(wb_req.stb)) |=> wb_rsp.ack)
        else begin
            errors++;
            $display("FAILED %0t: no ack on the cycle after stb", $time);
        end

    // no ack without a request
    ack_needs_stb: assert property (@(posedge ep50trig) disable iff (reset_global)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
        else begin
            errors++;
            $display("FAILED %0t: ack without a bus request", $time);
        end

    // one cycle wide
    ack_one_cycle: assert property (@(posedge ep50trig) disable iff (reset_global)
        wb_rsp.ack |=> !wb_rsp.ack)
        else begin
            errors++;
            $display("FAILED %0t: ack held for two cycles", $time);
        end

    read_value: assert property (@(posedge ep50trig) disable iff (reset_global)
        (wb_rsp.ack && chk_en) |-> (wb_rsp.dat == chk_exp))
        else begin
            errors++;
            $display("FAILED %0t: read returned %h, expected %h", $time,
                     $sampled(wb_rsp.dat), $sampled(chk_exp));
        end

    // bank output tracks the shadow between accesses
    params_match: assert property (@(posedge ep50trig) disable iff (reset_global)
        !wb_req.stb |-> (model_params == exp_params))
        else begin
            errors++;
            $display("FAILED %0t: model_params differs from the written coefficients", $time);
        end

    // deselected lane keeps sck low
    link_idle_sck: assert property (@(posedge ep50trig) disable iff (reset_global)
        link_tx.ssel_n |-> !link_tx.sck)
        else begin
            errors++;
            $display("FAILED %0t: sck high while the link is deselected", $time);
        end

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic limb_link_pkg::word_t lcg_next(input limb_link_pkg::word_t state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic next_random(output limb_link_pkg::word_t value);
        rng_state = lcg_next(rng_state);
        value = rng_state;
    endtask

    // busy bit 0, rx_valid bit 1, overrun bit 2, count in 15:8
    function automatic limb_link_pkg::word_t expected_status(
        input limb_link_pkg::frame_count_t count,
        input logic overrun,
        input logic rx_valid,
        input logic busy
    );
        limb_link_pkg::word_t s;
        s = '0;
        s[0] = busy;
        s[1] = rx_valid;
        s[2] = overrun;
        s[15:8] = count;
        return s;
    endfunction

    // one classic access, stb held until ack
    task automatic bus_cycle(
        input  logic                      wr,
        input  limb_link_pkg::reg_addr_t  addr,
        input  limb_link_pkg::word_t      wdata,
        input  logic                      check,
        input  limb_link_pkg::word_t      exp_dat,
        output limb_link_pkg::word_t      rdata
    );
        int waited;
        waited = 0;
        @(posedge ep50trig);
        wb_req  <= '{cyc: 1'b1, stb: 1'b1, we: wr, adr: addr, dat: wdata};
        chk_en  <= check;
        chk_exp <= exp_dat;
        do begin
            @(posedge ep50trig);
            waited++;
        end while (!wb_rsp.ack && waited < 8);
        if (!wb_rsp.ack) begin
            timeouts++;
            $display("timeout: no ack for the access to address %0d", addr);
        end
        rdata = wb_rsp.dat;
        wb_req <= '0;
        chk_en <= 1'b0;
        if (check) begin
            reads++;
        end
    endtask

    task automatic bus_write(input limb_link_pkg::reg_addr_t addr,
                             input limb_link_pkg::word_t data);
        limb_link_pkg::word_t unused;
        bus_cycle(1'b1, addr, data, 1'b0, '0, unused);
    endtask

    task automatic bus_read(input limb_link_pkg::reg_addr_t addr,
                            output limb_link_pkg::word_t data);
        bus_cycle(1'b0, addr, '0, 1'b0, '0, data);
    endtask

    task automatic read_and_check(input limb_link_pkg::reg_addr_t addr,
                                  input limb_link_pkg::word_t exp_dat);
        limb_link_pkg::word_t unused;
        bus_cycle(1'b0, addr, '0, 1'b1, exp_dat, unused);
    endtask

    // poll status until the sender is idle and a frame is waiting
    task automatic wait_frame_back();
        limb_link_pkg::word_t status;
        int polls;
        polls = 0;
        do begin
            bus_read(limb_link_pkg::addr_status, status);
            polls++;
        end while (!(status[1] && !status[0]) && polls < 1000);
        if (!(status[1] && !status[0])) begin
            timeouts++;
            $display("timeout: the length frame never came back over the loopback");
        end
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    initial begin
        limb_link_pkg::word_t     data;
        limb_link_pkg::word_t     first_word;
        limb_link_pkg::word_t     second_word;
        limb_link_pkg::reg_addr_t addr;
        int                       waited;

        wb_req    = '0;
        chk_en    = 1'b0;
        chk_exp   = '0;
        exp_count = '0;
        rng_state = 32'd7;
        errors    = 0;
        timeouts  = 0;
        reads     = 0;

        // reference defaults: 0.9, 0.9, 0, 80.0, 80.0, int 1, 0.2356, 0.0362, 0.0132
        exp_coef[0] = 32'h3F66_6666;
        exp_coef[1] = 32'h3F66_6666;
        exp_coef[2] = 32'h0000_0000;
        exp_coef[3] = 32'h42A0_0000;
        exp_coef[4] = 32'h42A0_0000;
        exp_coef[5] = 32'h0000_0001;
        exp_coef[6] = 32'h3E71_4120;
        exp_coef[7] = 32'h3D14_4674;
        exp_coef[8] = 32'h3C58_44D0;

        waited = 0;
        while (reset_global !== 1'b0 && waited < 20) begin
            @(posedge ep50trig);
            waited++;
        end
        if (reset_global !== 1'b0) begin
            timeouts++;
            $display("timeout: reset was never released");
        end

        // defaults after reset, status all clear
        for (int i = 0; i < 9; i++) begin
            read_and_check(limb_link_pkg::reg_addr_t'(i), exp_coef[i]);
        end
        read_and_check(limb_link_pkg::addr_status, '0);

        // random coefficient writes with readback
        repeat (12) begin
            next_random(data);
            addr = limb_link_pkg::reg_addr_t'(data % 32'd9);
            next_random(data);
            bus_write(addr, data);
            exp_coef[addr] = data;
            read_and_check(addr, data);
        end

        // one length frame around the loopback
        next_random(first_word);
        bus_write(limb_link_pkg::addr_length, first_word);
        wait_frame_back();
        exp_count++;
        read_and_check(limb_link_pkg::addr_status, expected_status(exp_count, 1'b0, 1'b1, 1'b0));
        read_and_check(limb_link_pkg::addr_rate, first_word);
        // rate read cleared rx_valid
        read_and_check(limb_link_pkg::addr_status, expected_status(exp_count, 1'b0, 1'b0, 1'b0));

        // second write lands mid frame
        next_random(first_word);
        next_random(second_word);
        bus_write(limb_link_pkg::addr_length, first_word);
        bus_write(limb_link_pkg::addr_length, second_word);
        read_and_check(limb_link_pkg::addr_status, expected_status(exp_count, 1'b1, 1'b0, 1'b1));
        wait_frame_back();
        exp_count++;
        read_and_check(limb_link_pkg::addr_status, expected_status(exp_count, 1'b1, 1'b1, 1'b0));
        read_and_check(limb_link_pkg::addr_length, first_word);
        read_and_check(limb_link_pkg::addr_rate, first_word);
        // quiet stretch longer than a frame, nothing more may arrive
        repeat (1000) @(posedge ep50trig);
        read_and_check(limb_link_pkg::addr_status, expected_status(exp_count, 1'b1, 1'b0, 1'b0));
        next_random(data);
        bus_write(limb_link_pkg::addr_status, data);
        read_and_check(limb_link_pkg::addr_status, expected_status(exp_count, 1'b0, 1'b0, 1'b0));

        repeat (2) @(posedge ep50trig);
        $display("run done: %0d checked reads, %0d value errors, %0d timeouts",
                 reads, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* limb_link_top.f */
source/limb_link_pkg.sv
source/host_regs.sv
source/spi_length_sender.sv
source/spi_rate_receiver.sv
source/limb_link_top.sv
testbench/tb_clock_gen.sv
testbench/tb_limb_link.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_limb_link
FILELIST  = limb_link_top.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# pass or fail comes from the log, not the exit code
run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
